//--- all.f
+incdir+testbench
common/lcd_axi_pkg.sv
common/lcd_map_pkg.sv
axi_slave/lcd_reg_read.sv
axi_slave/lcd_axi_write.sv
source/lcd_graph_buffer.sv
source/lcd_dispatch.sv
source/lcd_ctrl.sv
testbench/tb_lcd_ctrl.sv

//--- axi_slave/lcd_axi_write.sv
// lcd_axi_write: AXI-lite write channel with response, gated by the command path busy level
module lcd_axi_write (
    input  logic                pclk,
    input  logic                rst_n,
    input  lcd_axi_pkg::addr_t  s_awaddr_i,
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  lcd_axi_pkg::data_t  s_wdata_i,
    input  lcd_axi_pkg::strb_t  s_wstrb_i,
    input  logic                s_wlast_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    output logic                s_bvalid_o,
    output lcd_axi_pkg::resp_e  s_bresp_o,
    input  logic                s_bready_i,
    input  logic                busy_i,
    output logic                aw_fire_o,
    output lcd_axi_pkg::addr_t  aw_addr_o,
    output logic                beat_fire_o,
    output lcd_axi_pkg::addr_t  beat_addr_o,
    output lcd_axi_pkg::data_t  beat_data_o
);

    lcd_map_pkg::wr_state_e state_q;
    lcd_axi_pkg::addr_t     addr_q;
    logic                   w_fire;

    assign aw_fire_o = s_awvalid_i && s_awready_o;
    assign aw_addr_o = s_awaddr_i;
    assign w_fire    = s_wvalid_i && s_wready_o;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state_q     <= lcd_map_pkg::WR_IDLE;
            s_awready_o <= 1'b0;
            s_wready_o  <= 1'b0;
            s_bvalid_o  <= 1'b0;
        end else begin
            case (state_q)
                lcd_map_pkg::WR_IDLE: if (!busy_i) begin // hold off while dispatching
                    s_awready_o <= 1'b1;
                    state_q     <= lcd_map_pkg::WR_ADDR;
                end
                lcd_map_pkg::WR_ADDR: if (aw_fire_o) begin
                    s_awready_o <= 1'b0;
                    s_wready_o  <= 1'b1;
                    state_q     <= lcd_map_pkg::WR_DATA;
                end
                lcd_map_pkg::WR_DATA: if (w_fire && s_wlast_i) begin
                    s_wready_o <= 1'b0;
                    s_bvalid_o <= 1'b1;
                    state_q    <= lcd_map_pkg::WR_RESP;
                end
                lcd_map_pkg::WR_RESP: if (s_bready_i) begin
                    s_bvalid_o <= 1'b0;
                    state_q    <= lcd_map_pkg::WR_IDLE;
                end
                default: state_q <= lcd_map_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (aw_fire_o)
            addr_q <= s_awaddr_i;
    end

    // only full-word beats reach the command buffer
    assign beat_fire_o = w_fire && (s_wstrb_i == '1);
    assign beat_addr_o = addr_q;
    assign beat_data_o = s_wdata_i;
    assign s_bresp_o   = lcd_axi_pkg::RESP_OKAY;

    a_aw_b_excl: assert property (@(posedge pclk) disable iff (!rst_n)
        !(s_awready_o && s_bvalid_o));

endmodule

//--- axi_slave/lcd_reg_read.sv
// lcd_reg_read: single-beat AXI-lite read channel over the touch and LCD input status registers
module lcd_reg_read (
    input  logic                pclk,
    input  logic                rst_n,
    input  lcd_axi_pkg::addr_t  s_araddr_i,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    output lcd_axi_pkg::data_t  s_rdata_o,
    output lcd_axi_pkg::resp_e  s_rresp_o,
    output logic                s_rlast_o,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    input  lcd_axi_pkg::data_t  touch_reg_i
);

    lcd_map_pkg::rd_state_e state_q;
    lcd_map_pkg::rd_reg_e   op_q;
    lcd_axi_pkg::addr_t     addr_q;

    function automatic lcd_map_pkg::rd_reg_e decode_addr(lcd_axi_pkg::addr_t addr);
        if (addr == lcd_map_pkg::LCD_INPUT_ADDR)
            return lcd_map_pkg::RD_REG_LCD_INPUT;
        if (addr == lcd_map_pkg::TOUCH_INPUT_ADDR)
            return lcd_map_pkg::RD_REG_TOUCH;
        return lcd_map_pkg::RD_REG_NONE;
    endfunction

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state_q     <= lcd_map_pkg::RD_IDLE;
            s_arready_o <= 1'b1;
            s_rvalid_o  <= 1'b0;
        end else begin
            case (state_q)
                lcd_map_pkg::RD_IDLE: if (s_arvalid_i && s_arready_o) begin
                    s_arready_o <= 1'b0;
                    state_q     <= lcd_map_pkg::RD_DECODE;
                end
                lcd_map_pkg::RD_DECODE: state_q <= lcd_map_pkg::RD_FETCH;
                lcd_map_pkg::RD_FETCH: begin
                    s_rvalid_o <= 1'b1;
                    state_q    <= lcd_map_pkg::RD_RESP;
                end
                lcd_map_pkg::RD_RESP: if (s_rready_i) begin
                    s_rvalid_o  <= 1'b0;
                    s_arready_o <= 1'b1; // ready again next cycle
                    state_q     <= lcd_map_pkg::RD_IDLE;
                end
                default: state_q <= lcd_map_pkg::RD_IDLE;
            endcase
        end
    end

    // address, select and read data only move while the channel is busy
    always_ff @(posedge pclk) begin
        if (state_q == lcd_map_pkg::RD_IDLE && s_arvalid_i && s_arready_o)
            addr_q <= s_araddr_i;
        if (state_q == lcd_map_pkg::RD_DECODE)
            op_q <= decode_addr(addr_q);
        if (state_q == lcd_map_pkg::RD_FETCH) begin
            case (op_q)
                lcd_map_pkg::RD_REG_LCD_INPUT: s_rdata_o <= '1;
                lcd_map_pkg::RD_REG_TOUCH:     s_rdata_o <= touch_reg_i;
                default:                       s_rdata_o <= '0;
            endcase
        end
    end

    assign s_rresp_o = lcd_axi_pkg::RESP_OKAY;
    assign s_rlast_o = s_rvalid_o; // every read is one beat

    a_rvalid_hold: assert property (@(posedge pclk) disable iff (!rst_n)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o);

endmodule

//--- common/lcd_axi_pkg.sv
// lcd_axi_pkg: widths, types and response codes of the CPU-side AXI-lite bus
package lcd_axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // standard AXI response encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

endpackage

//--- common/lcd_map_pkg.sv
// lcd_map_pkg: register map, graph group length and FSM/opcode encodings of the LCD command path
package lcd_map_pkg;

    localparam lcd_axi_pkg::addr_t LCD_INPUT_ADDR   = 32'h1fd0_c000;
    localparam lcd_axi_pkg::addr_t TOUCH_INPUT_ADDR = 32'h1fd0_c004;
    localparam lcd_axi_pkg::addr_t WRITE_GRAPH_ADDR = 32'h1fd0_c008;

    localparam int GRAPH_ENTRIES = 7; // six commands plus the size word
    localparam int GRAPH_CMDS    = 6;

    typedef logic [2:0] idx_t;

    // read-side register select
    typedef enum logic [1:0] {
        RD_REG_LCD_INPUT = 2'd0,
        RD_REG_TOUCH     = 2'd1,
        RD_REG_NONE      = 2'd2
    } rd_reg_e;

    typedef enum logic [1:0] {
        BUF_IDLE    = 2'd0,
        BUF_CAPTURE = 2'd1,
        BUF_BUSY    = 2'd2
    } buf_state_e;

    typedef enum logic [1:0] {
        DISP_WAIT   = 2'd0,
        DISP_ISSUE  = 2'd1,
        DISP_SETTLE = 2'd2
    } disp_state_e;

    typedef enum logic [1:0] {
        RD_IDLE   = 2'd0,
        RD_DECODE = 2'd1,
        RD_FETCH  = 2'd2,
        RD_RESP   = 2'd3
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_ADDR = 2'd1,
        WR_DATA = 2'd2,
        WR_RESP = 2'd3
    } wr_state_e;

endpackage

//--- run.sh
#!/usr/bin/env bash
# build and run the LCD controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_lcd_ctrl -Mdir obj_dir \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vtb_lcd_ctrl)"
echo "$out"
echo "$out" | grep -qxF "=== PASS ===" && exit 0 || exit 1

//--- source/lcd_ctrl.sv
// lcd_ctrl: AXI-lite slave translating CPU writes into LCD graph command groups
module lcd_ctrl #(
    parameter int SETTLE_CYCLES = 2
) (
    input  logic                pclk,
    input  logic                rst_n,
    input  lcd_axi_pkg::addr_t  s_araddr_i,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    output lcd_axi_pkg::data_t  s_rdata_o,
    output lcd_axi_pkg::resp_e  s_rresp_o,
    output logic                s_rlast_o,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    input  lcd_axi_pkg::addr_t  s_awaddr_i,
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  lcd_axi_pkg::data_t  s_wdata_i,
    input  lcd_axi_pkg::strb_t  s_wstrb_i,
    input  logic                s_wlast_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    output lcd_axi_pkg::resp_e  s_bresp_o,
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    input  lcd_axi_pkg::data_t  touch_reg_i,
    input  logic                write_ok_i,
    output lcd_axi_pkg::addr_t  buffer_addr_o,
    output lcd_axi_pkg::data_t  buffer_data_o,
    output logic                data_valid_o,
    output lcd_axi_pkg::data_t  graph_size_o
);

    logic               busy, aw_fire, beat_fire, group_full, disp_done;
    lcd_axi_pkg::addr_t aw_addr, beat_addr, entry_addr;
    lcd_axi_pkg::data_t beat_data, entry_data, buf_graph_size;
    lcd_map_pkg::idx_t  disp_idx;

    lcd_reg_read u_reg_read (
        .pclk(pclk), .rst_n(rst_n),
        .s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o),
        .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o), .s_rlast_o(s_rlast_o),
        .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i), .touch_reg_i(touch_reg_i)
    );

    lcd_axi_write u_axi_write (
        .pclk(pclk), .rst_n(rst_n),
        .s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
        .s_wdata_i(s_wdata_i), .s_wstrb_i(s_wstrb_i), .s_wlast_i(s_wlast_i),
        .s_wvalid_i(s_wvalid_i), .s_wready_o(s_wready_o),
        .s_bvalid_o(s_bvalid_o), .s_bresp_o(s_bresp_o), .s_bready_i(s_bready_i),
        .busy_i(busy), .aw_fire_o(aw_fire), .aw_addr_o(aw_addr),
        .beat_fire_o(beat_fire), .beat_addr_o(beat_addr), .beat_data_o(beat_data)
    );

    lcd_graph_buffer u_graph_buffer (
        .pclk(pclk), .rst_n(rst_n),
        .aw_fire_i(aw_fire), .aw_addr_i(aw_addr),
        .beat_fire_i(beat_fire), .beat_addr_i(beat_addr), .beat_data_i(beat_data),
        .disp_idx_i(disp_idx), .disp_done_i(disp_done),
        .group_full_o(group_full), .busy_o(busy),
        .entry_addr_o(entry_addr), .entry_data_o(entry_data),
        .graph_size_o(buf_graph_size)
    );

    lcd_dispatch #(
        .SETTLE_CYCLES(SETTLE_CYCLES)
    ) u_dispatch (
        .pclk(pclk), .rst_n(rst_n),
        .group_full_i(group_full), .write_ok_i(write_ok_i),
        .entry_addr_i(entry_addr), .entry_data_i(entry_data),
        .graph_size_i(buf_graph_size),
        .disp_idx_o(disp_idx), .disp_done_o(disp_done),
        .buffer_addr_o(buffer_addr_o), .buffer_data_o(buffer_data_o),
        .data_valid_o(data_valid_o), .graph_size_o(graph_size_o)
    );

endmodule

//--- source/lcd_dispatch.sv
// lcd_dispatch: sends buffered graph commands to the LCD instruction unit with a settle gap
module lcd_dispatch #(
    parameter int SETTLE_CYCLES = 2
) (
    input  logic                pclk,
    input  logic                rst_n,
    input  logic                group_full_i,
    input  logic                write_ok_i,
    input  lcd_axi_pkg::addr_t  entry_addr_i,
    input  lcd_axi_pkg::data_t  entry_data_i,
    input  lcd_axi_pkg::data_t  graph_size_i,
    output lcd_map_pkg::idx_t   disp_idx_o,
    output logic                disp_done_o,
    output lcd_axi_pkg::addr_t  buffer_addr_o,
    output lcd_axi_pkg::data_t  buffer_data_o,
    output logic                data_valid_o,
    output lcd_axi_pkg::data_t  graph_size_o
);

    localparam int GAP_W = $clog2(SETTLE_CYCLES + 1);
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(SETTLE_CYCLES - 1);
    localparam lcd_map_pkg::idx_t LAST_CMD = lcd_map_pkg::idx_t'(lcd_map_pkg::GRAPH_CMDS - 1);
    localparam lcd_map_pkg::idx_t DONE_IDX = lcd_map_pkg::idx_t'(lcd_map_pkg::GRAPH_CMDS);

    lcd_map_pkg::disp_state_e state_q;
    lcd_map_pkg::idx_t        idx_q;
    logic [GAP_W-1:0]         gap_q;
    logic                     issue;

    // first entry may go out straight off group_full
    assign issue = write_ok_i && (idx_q != DONE_IDX) &&
                   (state_q == lcd_map_pkg::DISP_ISSUE ||
                    (state_q == lcd_map_pkg::DISP_WAIT && group_full_i));

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state_q      <= lcd_map_pkg::DISP_WAIT;
            idx_q        <= '0;
            gap_q        <= '0;
            data_valid_o <= 1'b0;
            disp_done_o  <= 1'b0;
            graph_size_o <= '0;
        end else begin
            data_valid_o <= 1'b0;
            disp_done_o  <= 1'b0;
            case (state_q)
                lcd_map_pkg::DISP_WAIT:
                    if (group_full_i)
                        state_q <= lcd_map_pkg::DISP_ISSUE;
                lcd_map_pkg::DISP_ISSUE:
                    if (idx_q == DONE_IDX && write_ok_i) begin
                        disp_done_o  <= 1'b1;
                        idx_q        <= '0;
                        graph_size_o <= '0;
                        state_q      <= lcd_map_pkg::DISP_WAIT;
                    end
                lcd_map_pkg::DISP_SETTLE: begin
                    gap_q <= gap_q + 1'b1;
                    if (gap_q == GAP_LAST)
                        state_q <= lcd_map_pkg::DISP_ISSUE;
                end
                default: state_q <= lcd_map_pkg::DISP_WAIT;
            endcase
            if (issue) begin
                data_valid_o <= 1'b1;
                idx_q        <= idx_q + 1'b1;
                gap_q        <= '0;
                if (idx_q == '0)
                    graph_size_o <= graph_size_i;
                // no gap needed before the done check
                state_q <= (idx_q == LAST_CMD) ? lcd_map_pkg::DISP_ISSUE
                                               : lcd_map_pkg::DISP_SETTLE;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (issue) begin
            buffer_addr_o <= entry_addr_i;
            buffer_data_o <= entry_data_i;
        end
    end

    assign disp_idx_o = idx_q;

    a_valid_pulse: assert property (@(posedge pclk) disable iff (!rst_n)
        data_valid_o |=> !data_valid_o);
    a_valid_ok: assert property (@(posedge pclk) disable iff (!rst_n)
        data_valid_o |-> $past(write_ok_i));

endmodule

//--- source/lcd_graph_buffer.sv
// lcd_graph_buffer: captures a seven-entry graph group and holds the command path busy
module lcd_graph_buffer (
    input  logic                pclk,
    input  logic                rst_n,
    input  logic                aw_fire_i,
    input  lcd_axi_pkg::addr_t  aw_addr_i,
    input  logic                beat_fire_i,
    input  lcd_axi_pkg::addr_t  beat_addr_i,
    input  lcd_axi_pkg::data_t  beat_data_i,
    input  lcd_map_pkg::idx_t   disp_idx_i,
    input  logic                disp_done_i,
    output logic                group_full_o,
    output logic                busy_o,
    output lcd_axi_pkg::addr_t  entry_addr_o,
    output lcd_axi_pkg::data_t  entry_data_o,
    output lcd_axi_pkg::data_t  graph_size_o
);

    localparam lcd_map_pkg::idx_t LAST_ENTRY =
        lcd_map_pkg::idx_t'(lcd_map_pkg::GRAPH_ENTRIES - 1);

    lcd_map_pkg::buf_state_e state_q;
    lcd_map_pkg::idx_t       cnt_q;
    lcd_axi_pkg::addr_t      addr_mem [lcd_map_pkg::GRAPH_ENTRIES];
    lcd_axi_pkg::data_t      data_mem [lcd_map_pkg::GRAPH_ENTRIES];
    logic                    capture;

    assign capture = (state_q == lcd_map_pkg::BUF_CAPTURE) && beat_fire_i;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state_q      <= lcd_map_pkg::BUF_IDLE;
            cnt_q        <= '0;
            busy_o       <= 1'b0;
            group_full_o <= 1'b0;
        end else begin
            group_full_o <= 1'b0;
            case (state_q)
                lcd_map_pkg::BUF_IDLE:
                    if (aw_fire_i && aw_addr_i == lcd_map_pkg::WRITE_GRAPH_ADDR) begin
                        cnt_q   <= '0;
                        state_q <= lcd_map_pkg::BUF_CAPTURE;
                    end
                lcd_map_pkg::BUF_CAPTURE: if (capture) begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == LAST_ENTRY) begin // seventh beat closes the group
                        busy_o       <= 1'b1;
                        group_full_o <= 1'b1;
                        state_q      <= lcd_map_pkg::BUF_BUSY;
                    end
                end
                lcd_map_pkg::BUF_BUSY: if (disp_done_i) begin
                    busy_o  <= 1'b0;
                    state_q <= lcd_map_pkg::BUF_IDLE;
                end
                default: state_q <= lcd_map_pkg::BUF_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (capture) begin
            addr_mem[cnt_q] <= beat_addr_i;
            data_mem[cnt_q] <= beat_data_i;
        end
    end

    assign entry_addr_o = addr_mem[disp_idx_i];
    assign entry_data_o = data_mem[disp_idx_i];
    assign graph_size_o = data_mem[LAST_ENTRY]; // size word, never dispatched

endmodule

//--- testbench/tb_lcd_tasks.svh
// tb_lcd_tasks provides AXI-lite bus tasks and an LCG random source for the testbench
`ifndef TB_LCD_TASKS_SVH
`define TB_LCD_TASKS_SVH

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// main-thread random stream
function automatic logic [31:0] rand32();
    rng = lcg_next(rng);
    return rng;
endfunction

task automatic bus_read(input lcd_axi_pkg::addr_t addr, output lcd_axi_pkg::data_t data,
                        output logic last);
    @(posedge pclk);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    @(posedge pclk);
    while (!s_arready_o) @(posedge pclk);
    s_arvalid_i <= 1'b0;
    s_rready_i  <= 1'b1;
    @(posedge pclk);
    while (!s_rvalid_o) @(posedge pclk);
    data = s_rdata_o;
    last = s_rlast_o;
    assert (s_rresp_o == lcd_axi_pkg::RESP_OKAY) else begin
        show_mismatch("s_rresp_o", 32'(s_rresp_o), 32'(lcd_axi_pkg::RESP_OKAY));
        bus_errs++;
    end
    s_rready_i <= 1'b0;
endtask

// stall holds bready low that many cycles after the data beat
task automatic bus_write(input lcd_axi_pkg::addr_t addr, input lcd_axi_pkg::data_t data,
                         input lcd_axi_pkg::strb_t strb, input int stall);
    wr_addr_q.push_back(addr);
    wr_data_q.push_back(data);
    wr_strb_q.push_back(strb);
    @(posedge pclk);
    s_awaddr_i  <= addr;
    s_awvalid_i <= 1'b1;
    @(posedge pclk);
    while (!s_awready_o) @(posedge pclk);
    s_awvalid_i <= 1'b0;
    s_wdata_i   <= data;
    s_wstrb_i   <= strb;
    s_wlast_i   <= 1'b1;
    s_wvalid_i  <= 1'b1;
    @(posedge pclk);
    while (!s_wready_o) @(posedge pclk);
    s_wvalid_i <= 1'b0;
    s_wlast_i  <= 1'b0;
    repeat (stall) begin
        @(posedge pclk);
        assert (s_bvalid_o && !s_awready_o) else begin
            $display("write response not held while bready was low at %0t", $time);
            bus_errs++;
        end
    end
    s_bready_i <= 1'b1;
    @(posedge pclk);
    while (!s_bvalid_o) @(posedge pclk);
    assert (s_bresp_o == lcd_axi_pkg::RESP_OKAY) else begin
        show_mismatch("s_bresp_o", 32'(s_bresp_o), 32'(lcd_axi_pkg::RESP_OKAY));
        bus_errs++;
    end
    s_bready_i <= 1'b0;
endtask

`endif

//--- testbench/tb_lcd_ctrl.sv
// tb_lcd_ctrl drives CPU bus traffic into the LCD controller against an LCD unit model
module tb_lcd_ctrl;

    localparam int SETTLE_CYCLES = 2;
    localparam logic [31:0] SEED = 32'he379_8362;
    localparam int BUS_OPS = 21; // 3 reads and 18 writes
    localparam int DISPATCHES = 2 * lcd_map_pkg::GRAPH_CMDS;
    localparam int TIMEOUT_CYCLES = 2 * (40 * BUS_OPS + 20 * DISPATCHES);

    logic               pclk = 1'b0;
    logic               rst_n;
    lcd_axi_pkg::addr_t s_araddr_i, s_awaddr_i, buffer_addr_o;
    lcd_axi_pkg::data_t s_rdata_o, s_wdata_i, touch_reg_i, buffer_data_o, graph_size_o;
    lcd_axi_pkg::strb_t s_wstrb_i;
    lcd_axi_pkg::resp_e s_rresp_o, s_bresp_o;
    logic               s_arvalid_i, s_arready_o, s_rlast_o, s_rvalid_o, s_rready_i;
    logic               s_awvalid_i, s_awready_o, s_wlast_i, s_wvalid_i, s_wready_o;
    logic               s_bvalid_o, s_bready_i, data_valid_o;
    logic               write_ok_i = 1'b1;

    logic [31:0]        rng;
    logic [31:0]        lcd_rng = SEED;
    int                 ok_wait = 0;
    int                 cycle_cnt = 0;
    int                 bus_errs = 0;
    int                 disp_errs = 0;
    int                 total_pulses = 0;
    int                 last_pulse_cyc = 0;
    int                 grp_base = 0;
    int                 pulse_idx;
    logic               group_open = 1'b0;
    logic               ok_prev = 1'b0;
    logic [63:0]        exp_entry, exp_size;
    lcd_axi_pkg::addr_t wr_addr_q[$];
    lcd_axi_pkg::data_t wr_data_q[$];
    lcd_axi_pkg::strb_t wr_strb_q[$];

    `include "tb_lcd_tasks.svh"

    lcd_ctrl #(.SETTLE_CYCLES(SETTLE_CYCLES)) dut_i (.*);

    always #5 pclk = ~pclk;

    always @(posedge pclk) cycle_cnt <= cycle_cnt + 1;

    function automatic void show_mismatch(input string sig, input logic [31:0] got,
                                          input logic [31:0] exp);
        $display("Error at %0t: %s = %h, expected %h", $time, sig, got, exp);
    endfunction

    // k-th full-strobe write counted from the write that opened the group
    function automatic logic [63:0] captured_entry(input int k);
        int   n;
        logic armed;
        n = 0;
        armed = 1'b0;
        foreach (wr_addr_q[i]) begin
            if (wr_addr_q[i] == lcd_map_pkg::WRITE_GRAPH_ADDR)
                armed = 1'b1;
            if (armed && wr_strb_q[i] == '1) begin
                if (n == k)
                    return {wr_addr_q[i], wr_data_q[i]};
                n++;
            end
        end
        return '0;
    endfunction

    function automatic lcd_axi_pkg::addr_t plain_addr(input logic [31:0] r);
        lcd_axi_pkg::addr_t a;
        a = {r[31:2], 2'b00};
        if (a[31:4] == 28'h1fd0_c00) // keep clear of the register map
            a = a ^ 32'h100;
        return a;
    endfunction

    // LCD unit model goes busy for 1..4 cycles after each command
    always @(posedge pclk) begin
        if (data_valid_o) begin
            write_ok_i <= 1'b0;
            ok_wait    <= 1 + int'(lcd_rng[17:16]);
            lcd_rng    <= lcg_next(lcd_rng);
        end else if (ok_wait > 0) begin
            ok_wait <= ok_wait - 1;
            if (ok_wait == 1)
                write_ok_i <= 1'b1;
        end
    end

    always @(posedge pclk) begin
        if (rst_n && data_valid_o) begin
            pulse_idx = total_pulses - grp_base;
            if (!group_open || pulse_idx >= lcd_map_pkg::GRAPH_CMDS) begin
                $display("unexpected data_valid_o pulse at %0t", $time);
                disp_errs++;
            end else begin
                exp_entry = captured_entry(pulse_idx);
                exp_size  = captured_entry(lcd_map_pkg::GRAPH_ENTRIES - 1);
                assert (buffer_addr_o == exp_entry[63:32]) else begin
                    show_mismatch("buffer_addr_o", buffer_addr_o, exp_entry[63:32]);
                    disp_errs++;
                end
                assert (buffer_data_o == exp_entry[31:0]) else begin
                    show_mismatch("buffer_data_o", buffer_data_o, exp_entry[31:0]);
                    disp_errs++;
                end
                assert (graph_size_o == exp_size[31:0]) else begin
                    show_mismatch("graph_size_o", graph_size_o, exp_size[31:0]);
                    disp_errs++;
                end
                if (pulse_idx > 0) begin
                    assert (cycle_cnt - last_pulse_cyc >= SETTLE_CYCLES) else begin
                        $display("pulses only %0d cycles apart at %0t",
                                 cycle_cnt - last_pulse_cyc, $time);
                        disp_errs++;
                    end
                end
            end
            assert (ok_prev) else begin
                $display("data_valid_o raised while write_ok_i was low at %0t", $time);
                disp_errs++;
            end
            total_pulses   <= total_pulses + 1;
            last_pulse_cyc <= cycle_cnt;
        end
        if (rst_n && group_open && s_awready_o && total_pulses > grp_base &&
            total_pulses - grp_base < lcd_map_pkg::GRAPH_CMDS) begin
            $display("awready seen during dispatch at %0t", $time);
            disp_errs++;
        end
        ok_prev <= write_ok_i;
    end

    task automatic check_read(input lcd_axi_pkg::data_t got, input lcd_axi_pkg::data_t exp,
                              input logic last);
        assert (got == exp) else begin
            show_mismatch("s_rdata_o", got, exp);
            bus_errs++;
        end
        assert (last) else begin
            show_mismatch("s_rlast_o", 32'(last), 32'd1);
            bus_errs++;
        end
    endtask

    task automatic send_group(input logic with_partial);
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_strb_q.delete();
        grp_base   <= total_pulses;
        group_open <= 1'b1;
        bus_write(lcd_map_pkg::WRITE_GRAPH_ADDR, rand32(), '1, 0);
        for (int i = 1; i < lcd_map_pkg::GRAPH_ENTRIES; i++) begin
            if (with_partial && (i == 2 || i == 5)) // never all four lanes
                bus_write(plain_addr(rand32()), rand32(),
                          lcd_axi_pkg::strb_t'(rand32()) & 4'b0111, 0);
            bus_write(plain_addr(rand32()), rand32(), '1, 0);
        end
        while (total_pulses - grp_base < lcd_map_pkg::GRAPH_CMDS) @(posedge pclk);
        while (!s_awready_o) @(posedge pclk);
        assert (graph_size_o == '0) else begin
            show_mismatch("graph_size_o", graph_size_o, '0);
            bus_errs++;
        end
        group_open <= 1'b0;
    endtask

    initial begin
        lcd_axi_pkg::data_t rd;
        lcd_axi_pkg::data_t touch_val;
        logic               last;
        rst_n       = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = '0;
        s_wlast_i   = 1'b0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        touch_reg_i = '0;
        rng         = SEED;
        repeat (2) @(posedge pclk);
        rst_n <= 1'b1;

        touch_val = rand32();
        touch_reg_i <= touch_val;
        bus_read(lcd_map_pkg::TOUCH_INPUT_ADDR, rd, last);
        check_read(rd, touch_val, last);
        bus_read(lcd_map_pkg::LCD_INPUT_ADDR, rd, last);
        check_read(rd, '1, last);
        bus_read(plain_addr(rand32()), rd, last);
        check_read(rd, '0, last);

        send_group(1'b0);
        bus_write(plain_addr(rand32()), rand32(), '1, 0); // accepted again with no pulse
        send_group(1'b1);
        bus_write(plain_addr(rand32()), rand32(), '1, 5);
        repeat (20) @(posedge pclk); // window for stray pulses

        assert (total_pulses == DISPATCHES) else begin
            show_mismatch("data_valid_o count", total_pulses, DISPATCHES);
            bus_errs++;
        end
        $display("errors: %0d bus, %0d dispatch; %0d pulses", bus_errs, disp_errs, total_pulses);
        if (bus_errs + disp_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        wait (cycle_cnt == TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
        $display("errors: %0d bus, %0d dispatch; %0d pulses", bus_errs, disp_errs, total_pulses);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
